//--- rtl/huff_pkg.sv
`default_nettype none

package huff_pkg;

    localparam int DEF_NODE_AW   = 7;   // 128 tree nodes
    localparam int DEF_MAX_DEPTH = 16;  // longest code in bits

    typedef logic [8:0] child_t;        // bit 8 set for internal node, else leaf symbol in 7:0

    typedef struct packed {
        child_t left;                   // bits 17:9
        child_t right;                  // bits 8:0
    } node_t;

    localparam child_t CHILD_NONE = 9'h180;  // empty tree marker

    typedef enum logic [2:0] {
        IDLE,
        FETCH,      // wait for node read
        LEFT,
        RIGHT,
        EMIT,       // entry on the handshake
        BACKTRACK,
        TRACK,      // replay path from root
        DONE
    } walk_state_t;

    // apb byte offsets
    localparam logic [31:0] REG_CTRL      = 32'h00;
    localparam logic [31:0] REG_STATUS    = 32'h04;
    localparam logic [31:0] REG_ROOT      = 32'h08;
    localparam logic [31:0] REG_NODE_ADDR = 32'h0C;
    localparam logic [31:0] REG_NODE_DATA = 32'h10;
    localparam logic [31:0] REG_CB_SEL    = 32'h14;
    localparam logic [31:0] REG_CB_DATA   = 32'h18;

endpackage

`default_nettype wire

//--- rtl/cb_entry_if.sv
`default_nettype none

interface cb_entry_if #(
    parameter int MAX_DEPTH = 16
);
    localparam int LW = $clog2(MAX_DEPTH + 1);  // length field width

    logic                    valid;   // held until ready
    logic                    ready;   // low while host reads the table
    logic [7:0]              symbol;
    logic [LW+MAX_DEPTH-1:0] code;    // length on top, right-aligned moves below

    modport walker (
        output valid,
        output symbol,
        output code,
        input  ready
    );

    modport store (
        input  valid,
        input  symbol,
        input  code,
        output ready
    );

endinterface

`default_nettype wire

//--- rtl/huff_apb_regs.sv
`default_nettype none

module huff_apb_regs #(
    parameter int  NODE_AW   = 7,
    parameter int  MAX_DEPTH = 16,
    localparam int LW        = $clog2(MAX_DEPTH + 1)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  start,
    output logic [NODE_AW-1:0]    root,
    input  logic                  busy,
    input  logic                  done,
    input  logic                  depth_err,
    output logic                  node_we,
    output logic [NODE_AW-1:0]    node_waddr,
    output huff_pkg::node_t       node_wdata,
    output logic [7:0]            cb_sel,
    output logic                  cb_rd,
    input  logic [LW+MAX_DEPTH:0] cb_rdata,
    input  logic [7:0]            entry_count
);
    import huff_pkg::*;

    logic               access;
    logic               wr_ok;
    logic               sel_ctrl;
    logic               sel_status;
    logic               sel_root;
    logic               sel_naddr;
    logic               sel_ndata;
    logic               sel_cbsel;
    logic               sel_cbdata;
    logic               mapped;
    logic               guarded;
    logic [NODE_AW-1:0] node_addr;   // auto-increments on node data writes
    logic [31:0]        cb_word;

    assign access     = psel & penable;                  // zero wait, access phase only
    assign sel_ctrl   = (paddr == REG_CTRL[7:0]);
    assign sel_status = (paddr == REG_STATUS[7:0]);
    assign sel_root   = (paddr == REG_ROOT[7:0]);
    assign sel_naddr  = (paddr == REG_NODE_ADDR[7:0]);
    assign sel_ndata  = (paddr == REG_NODE_DATA[7:0]);
    assign sel_cbsel  = (paddr == REG_CB_SEL[7:0]);
    assign sel_cbdata = (paddr == REG_CB_DATA[7:0]);

    assign mapped  = sel_ctrl | sel_status | sel_root | sel_naddr |
                     sel_ndata | sel_cbsel | sel_cbdata;
    assign guarded = sel_ctrl | sel_root | sel_ndata;    // would disturb a running walk

    assign pready  = 1'b1;
    assign pslverr = access & (~mapped | (pwrite & busy & guarded));
    assign wr_ok   = access & pwrite & ~pslverr;

    assign node_we    = wr_ok & sel_ndata;
    assign node_waddr = node_addr;
    assign node_wdata = node_t'(pwdata[17:0]);           // left child in 17:9
    assign cb_rd      = access & ~pwrite & sel_cbdata;   // store stalls walker this cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start     <= 1'b0;
            root      <= '0;
            node_addr <= '0;
            cb_sel    <= '0;
        end else begin
            start <= wr_ok & sel_ctrl & pwdata[0];       // one cycle pulse
            if (wr_ok & sel_root)
                root <= pwdata[NODE_AW-1:0];
            if (wr_ok & sel_naddr)
                node_addr <= pwdata[NODE_AW-1:0];
            else if (node_we)
                node_addr <= node_addr + 1'b1;
            if (wr_ok & sel_cbsel)
                cb_sel <= pwdata[7:0];
        end
    end

    // codebook word: valid 31, length 20:16, code 15:0
    always_comb begin
        cb_word                = '0;
        cb_word[31]            = cb_rdata[LW+MAX_DEPTH];
        cb_word[16 +: LW]      = cb_rdata[MAX_DEPTH +: LW];
        cb_word[MAX_DEPTH-1:0] = cb_rdata[MAX_DEPTH-1:0];
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (1'b1)
                sel_status: prdata = {16'h0, entry_count, 5'h0, depth_err, done, busy};
                sel_root:   prdata[NODE_AW-1:0] = root;
                sel_naddr:  prdata[NODE_AW-1:0] = node_addr;
                sel_cbsel:  prdata[7:0] = cb_sel;
                sel_cbdata: prdata = cb_word;
                default:    prdata = '0;                 // ctrl reads zero
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/htree_ram.sv
`default_nettype none

module htree_ram #(
    parameter int NODE_AW = 7
) (
    input  logic               clk,
    input  logic               we,
    input  logic [NODE_AW-1:0] waddr,
    input  huff_pkg::node_t    wdata,
    input  logic [NODE_AW-1:0] raddr,
    output huff_pkg::node_t    rdata
);
    import huff_pkg::*;

    node_t mem [2**NODE_AW];   // loaded by host before start

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];   // one cycle read latency
    end

endmodule

`default_nettype wire

//--- rtl/cb_walker.sv
`default_nettype none

module cb_walker #(
    parameter int  NODE_AW   = 7,
    parameter int  MAX_DEPTH = 16,
    localparam int LW        = $clog2(MAX_DEPTH + 1)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [NODE_AW-1:0] root,
    output logic [NODE_AW-1:0] rd_addr,
    input  huff_pkg::node_t    rd_data,
    output logic               busy,
    output logic               done,
    output logic               depth_err,
    cb_entry_if.walker         ent
);
    import huff_pkg::*;

    walk_state_t        state;
    logic [NODE_AW-1:0] idx;        // node being read
    logic [MAX_DEPTH:0] path;       // marker bit above the moves, newest move in bit 0
    logic [LW-1:0]      depth;      // moves in path
    logic [LW-1:0]      pos;        // moves still to replay in TRACK
    logic               in_track;   // FETCH returns to TRACK instead of LEFT
    logic [7:0]         sym;        // leaf symbol held for EMIT
    child_t             child;
    logic [MAX_DEPTH:0] marker;
    logic [MAX_DEPTH:0] moves;

    // child picked by the current state
    always_comb begin
        case (state)
            RIGHT:   child = rd_data.right;
            TRACK:   child = (pos != '0 && path[pos - 1'b1]) ? rd_data.right : rd_data.left;
            default: child = rd_data.left;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            idx       <= '0;
            path      <= (MAX_DEPTH + 1)'(1);
            depth     <= '0;
            pos       <= '0;
            in_track  <= 1'b0;
            sym       <= '0;
            depth_err <= 1'b0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        idx       <= root;
                        path      <= (MAX_DEPTH + 1)'(1);   // marker only
                        depth     <= '0;
                        in_track  <= 1'b0;
                        depth_err <= 1'b0;
                        state     <= FETCH;
                    end
                end
                FETCH: state <= in_track ? TRACK : LEFT;    // rd_data valid next cycle
                LEFT, RIGHT: begin
                    if (child == CHILD_NONE) begin
                        state <= DONE;                        // empty tree
                    end else if (depth == LW'(MAX_DEPTH)) begin
                        depth_err <= 1'b1;                    // path would overflow
                        state     <= DONE;
                    end else begin
                        path  <= {path[MAX_DEPTH-1:0], state == RIGHT};  // 0 left, 1 right
                        depth <= depth + 1'b1;
                        if (child[8]) begin
                            idx      <= child[NODE_AW-1:0];   // descend into internal node
                            in_track <= 1'b0;
                            state    <= FETCH;
                        end else begin
                            sym   <= child[7:0];
                            state <= EMIT;
                        end
                    end
                end
                EMIT: begin
                    if (ent.ready)
                        state <= BACKTRACK;                   // store took the entry
                end
                BACKTRACK: begin
                    if (depth == '0) begin
                        state <= DONE;                        // root with right side done
                    end else begin
                        path  <= {1'b0, path[MAX_DEPTH:1]};   // pop newest move
                        depth <= depth - 1'b1;
                        if (!path[0]) begin
                            idx      <= root;                 // popped a left, replay then go right
                            pos      <= depth - 1'b1;
                            in_track <= 1'b1;
                            state    <= FETCH;
                        end
                    end
                end
                TRACK: begin
                    if (pos == '0) begin
                        state <= RIGHT;                       // back at the branching node
                    end else begin
                        idx   <= child[NODE_AW-1:0];
                        pos   <= pos - 1'b1;
                        state <= FETCH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign rd_addr = idx;
    assign busy    = (state != IDLE) && (state != DONE);
    assign done    = (state == DONE);                         // held until next start

    assign marker = (MAX_DEPTH + 1)'(1) << depth;
    assign moves  = path ^ marker;                            // strip marker, first move is msb

    assign ent.valid  = (state == EMIT);
    assign ent.symbol = sym;
    assign ent.code   = {depth, moves[MAX_DEPTH-1:0]};

endmodule

`default_nettype wire

//--- rtl/codebook_store.sv
`default_nettype none

module codebook_store #(
    parameter int  MAX_DEPTH = 16,
    localparam int LW        = $clog2(MAX_DEPTH + 1)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    cb_entry_if.store             ent,
    input  logic [7:0]            cb_sel,
    input  logic                  cb_rd,
    output logic [LW+MAX_DEPTH:0] cb_rdata,
    output logic [7:0]            entry_count
);
    logic [255:0]         vld;              // one per symbol
    logic [LW-1:0]        len_mem  [256];
    logic [MAX_DEPTH-1:0] code_mem [256];
    logic                 take;

    assign ent.ready = ~cb_rd;              // single read port, host wins
    assign take      = ent.valid & ent.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld         <= '0;
            entry_count <= '0;
        end else if (clear) begin
            vld         <= '0;              // new run
            entry_count <= '0;
        end else if (take) begin
            vld[ent.symbol] <= 1'b1;
            entry_count     <= entry_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            len_mem[ent.symbol]  <= ent.code[MAX_DEPTH +: LW];
            code_mem[ent.symbol] <= ent.code[MAX_DEPTH-1:0];
        end
    end

    // zero word for symbols not in the tree
    assign cb_rdata = vld[cb_sel] ? {1'b1, len_mem[cb_sel], code_mem[cb_sel]} : '0;

endmodule

`default_nettype wire

//--- rtl/huff_cb_top.sv
`default_nettype none

module huff_cb_top #(
    parameter int  NODE_AW   = huff_pkg::DEF_NODE_AW,
    parameter int  MAX_DEPTH = huff_pkg::DEF_MAX_DEPTH,
    localparam int LW        = $clog2(MAX_DEPTH + 1)
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        done
);
    import huff_pkg::*;

    logic                  start;        // also clears the store
    logic [NODE_AW-1:0]    root;
    logic                  busy;
    logic                  depth_err;
    logic                  node_we;
    logic [NODE_AW-1:0]    node_waddr;
    node_t                 node_wdata;
    logic [NODE_AW-1:0]    rd_addr;
    node_t                 rd_data;
    logic [7:0]            cb_sel;
    logic                  cb_rd;
    logic [LW+MAX_DEPTH:0] cb_rdata;
    logic [7:0]            entry_count;

    cb_entry_if #(.MAX_DEPTH(MAX_DEPTH)) ent_if ();

    huff_apb_regs #(.NODE_AW(NODE_AW), .MAX_DEPTH(MAX_DEPTH)) u_regs (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .start(start), .root(root), .busy(busy), .done(done), .depth_err(depth_err),
        .node_we(node_we), .node_waddr(node_waddr), .node_wdata(node_wdata),
        .cb_sel(cb_sel), .cb_rd(cb_rd), .cb_rdata(cb_rdata), .entry_count(entry_count)
    );

    htree_ram #(.NODE_AW(NODE_AW)) u_ram (
        .clk(clk), .we(node_we), .waddr(node_waddr), .wdata(node_wdata),
        .raddr(rd_addr), .rdata(rd_data)
    );

    cb_walker #(.NODE_AW(NODE_AW), .MAX_DEPTH(MAX_DEPTH)) u_walker (
        .clk(clk), .rst(rst), .start(start), .root(root),
        .rd_addr(rd_addr), .rd_data(rd_data),
        .busy(busy), .done(done), .depth_err(depth_err), .ent(ent_if.walker)
    );

    codebook_store #(.MAX_DEPTH(MAX_DEPTH)) u_store (
        .clk(clk), .rst(rst), .clear(start), .ent(ent_if.store),
        .cb_sel(cb_sel), .cb_rd(cb_rd), .cb_rdata(cb_rdata), .entry_count(entry_count)
    );

endmodule

`default_nettype wire

//--- tb/tb_huff_cb.sv
`default_nettype none

module tb_huff_cb;
    timeunit 1ns;
    timeprecision 100ps;
    import huff_pkg::*;

    localparam int NODE_AW   = 7;
    localparam int MAX_DEPTH = 16;
    // walk budget per tree node plus apb traffic per run (9 runs incl. reset scan)
    localparam int RUN_NODES      = 4 + 1 + 1 + 4 * 39 + 18;
    localparam int TIMEOUT_CYCLES = RUN_NODES * MAX_DEPTH * 6 + 9 * 2000 + 20;

    logic        clk = 1'b0;
    logic        rst;
    logic        psel, penable, pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr, done;
    int          cycles = 0;
    logic [31:0] rng;                          // xorshift state
    logic [8:0]  t_left  [128];                // tb copy of the tree
    logic [8:0]  t_right [128];
    int          node_dep [128];
    bit          sym_used [256];
    logic [31:0] exp_word [256];               // expected cb_data per symbol
    int          exp_count;

    huff_cb_top #(.NODE_AW(NODE_AW), .MAX_DEPTH(MAX_DEPTH)) UUT (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .done(done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES)
            stop_on_error("timeout: the tree walk or APB traffic never finished");
    end

    task stop_on_error(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
            else stop_on_error($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    // handshake stays put while the store is busy with a host read
    assert property (@(posedge clk) disable iff (rst) pready)
        else stop_on_error("pready dropped during an APB transfer");
    assert property (@(posedge clk) disable iff (rst)
        (UUT.ent_if.valid && !UUT.ent_if.ready) |=> (UUT.ent_if.valid &&
        $stable(UUT.ent_if.symbol) && $stable(UUT.ent_if.code)))
        else stop_on_error("codebook entry changed or vanished while stalled");
    assert property (@(posedge clk) disable iff (rst)
        UUT.ent_if.valid |-> (UUT.ent_if.code[20:16] <= MAX_DEPTH))
        else stop_on_error("walker offered an entry longer than the maximum depth");
    assert property (@(posedge clk) disable iff (rst) (done && !UUT.start) |=> done)
        else stop_on_error("done dropped without a new start");

    function logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function logic [8:0] inode(input int i);
        return 9'h100 | 9'(i);
    endfunction

    function logic [8:0] leaf(input logic [7:0] s);
        return {1'b0, s};
    endfunction

    function logic [7:0] new_symbol();
        logic [7:0] s;
        s = 8'(xorshift32());
        while (sym_used[s])
            s = 8'(xorshift32());
        sym_used[s] = 1'b1;
        return s;
    endfunction

    // apb transfer, drive 1 ns after the edge, sample at mid access phase
    task xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
              input logic exp_err, output logic [31:0] rdata);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        check_eq($sformatf("pslverr at 0x%h", addr), 32'(exp_err), 32'(pslverr));
        rdata = prdata;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        xfer(1'b1, addr[7:0], data, 1'b0, unused);
    endtask

    task apb_read(input logic [31:0] addr, output logic [31:0] data);
        xfer(1'b0, addr[7:0], 32'h0, 1'b0, data);
    endtask

    task load_tree(input int first, input int count);
        apb_write(REG_NODE_ADDR, first);
        for (int i = first; i < first + count; i++)
            apb_write(REG_NODE_DATA, {14'h0, t_left[i], t_right[i]});
        apb_write(REG_ROOT, first);
    endtask

    task wait_done();
        @(posedge clk);
        #1;                                    // done from the old run drops here
        while (!done) begin
            @(posedge clk);
            #1;
        end
    endtask

    task clear_expect();
        for (int s = 0; s < 256; s++)
            exp_word[s] = 32'h0;
        exp_count = 0;
    endtask

    // code is the move sequence from the root msb first, length is the leaf depth
    task expect_codes(input int root_idx);
        int         q_idx [$];
        logic [15:0] q_code [$];
        int         q_len [$];
        int         idx, len, side;
        logic [15:0] code;
        logic [8:0] kid;
        q_idx.push_back(root_idx);
        q_code.push_back(16'h0);
        q_len.push_back(0);
        while (q_idx.size() > 0) begin
            idx  = q_idx.pop_back();
            code = q_code.pop_back();
            len  = q_len.pop_back();
            for (side = 0; side < 2; side++) begin
                kid = side ? t_right[idx] : t_left[idx];
                if (kid[8]) begin
                    q_idx.push_back(kid[6:0]);
                    q_code.push_back({code[14:0], side[0]});
                    q_len.push_back(len + 1);
                end else begin
                    exp_word[kid[7:0]] = {1'b1, 10'h0, 5'(len + 1), code[14:0], side[0]};
                    exp_count++;
                end
            end
        end
    endtask

    // grows from a two-leaf root by splitting random leaves, depth kept legal
    task automatic build_random_tree(input int nsym);
        int slots [$];
        int pick, slot, p, next;
        logic [8:0] old;
        for (int s = 0; s < 256; s++)
            sym_used[s] = 1'b0;
        t_left[0]   = leaf(new_symbol());
        t_right[0]  = leaf(new_symbol());
        node_dep[0] = 0;
        slots       = '{0, 1};                 // node * 2 + side
        next        = 1;
        while (slots.size() < nsym) begin
            pick = xorshift32() % slots.size();
            slot = slots[pick];
            p    = slot >> 1;
            if (node_dep[p] + 2 > MAX_DEPTH)
                continue;
            old            = slot[0] ? t_right[p] : t_left[p];
            t_left[next]   = old;
            t_right[next]  = leaf(new_symbol());
            node_dep[next] = node_dep[p] + 1;
            if (slot[0])
                t_right[p] = inode(next);
            else
                t_left[p] = inode(next);
            slots.delete(pick);
            slots.push_back(next * 2);
            slots.push_back(next * 2 + 1);
            next++;
        end
    endtask

    task check_table();
        logic [31:0] word;
        for (int s = 0; s < 256; s++) begin
            apb_write(REG_CB_SEL, s);
            apb_read(REG_CB_DATA, word);
            check_eq($sformatf("cb_data[0x%h]", 8'(s)), exp_word[s], word);
        end
    endtask

    task check_status(input int count, input logic derr);
        logic [31:0] word;
        apb_read(REG_STATUS, word);
        check_eq("status", {16'h0, 8'(count), 5'h0, derr, 1'b1, 1'b0}, word);
        check_eq("done", 32'h1, 32'(done));
    endtask

    task run_and_check(input int root_idx, input int count);
        load_tree(root_idx, count);
        clear_expect();
        expect_codes(root_idx);
        apb_write(REG_CTRL, 32'h1);
        wait_done();
        check_status(exp_count, 1'b0);
        check_table();
    endtask

    initial begin
        logic [31:0] word;
        int nsym;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h0;
        pwdata  = 32'h0;
        rng     = 32'h7b1d;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        check_eq("done", 32'h0, 32'(done));    // idle after reset
        apb_read(REG_STATUS, word);
        check_eq("status", 32'h0, word);
        clear_expect();
        check_table();

        t_left[10] = inode(11);                // five symbols, root at 10
        t_right[10] = inode(12);
        t_left[11] = leaf(8'h41);
        t_right[11] = inode(13);
        t_left[12] = leaf(8'h44);
        t_right[12] = leaf(8'h45);
        t_left[13] = leaf(8'h42);
        t_right[13] = leaf(8'h43);
        load_tree(10, 4);
        clear_expect();
        expect_codes(10);
        apb_write(REG_CTRL, 32'h1);
        apb_read(REG_STATUS, word);
        check_eq("status busy", 32'h1, 32'(word[0]));
        repeat (8) apb_read(REG_CB_DATA, word);  // host reads stall the walker
        wait_done();
        check_status(5, 1'b0);
        check_table();

        t_left[20] = CHILD_NONE;               // empty tree
        t_right[20] = CHILD_NONE;
        load_tree(20, 1);
        clear_expect();
        apb_write(REG_CTRL, 32'h1);
        wait_done();
        check_status(0, 1'b0);
        check_table();
        t_left[21] = leaf(8'h30);
        t_right[21] = leaf(8'hc7);
        run_and_check(21, 1);

        repeat (3) begin
            nsym = 12 + xorshift32() % 29;
            build_random_tree(nsym);
            run_and_check(0, nsym - 1);
        end

        xfer(1'b0, 8'h40, 32'h0, 1'b1, word);  // unmapped while idle
        apb_write(REG_NODE_ADDR, 32'h0);       // a leaked node write would hit the live root
        apb_write(REG_CTRL, 32'h1);
        xfer(1'b1, REG_NODE_DATA[7:0], 32'h3ffff, 1'b1, word);
        xfer(1'b1, REG_ROOT[7:0], 32'd5, 1'b1, word);
        xfer(1'b1, REG_CTRL[7:0], 32'h1, 1'b1, word);
        xfer(1'b1, 8'h1c, 32'h0, 1'b1, word);
        wait_done();
        check_status(exp_count, 1'b0);         // same tree, same table
        check_table();
        apb_read(REG_ROOT, word);
        check_eq("root", 32'h0, word);
        apb_read(REG_NODE_ADDR, word);
        check_eq("node_addr", 32'h0, word);

        for (int i = 0; i < 18; i++) begin     // chain with leaves down to depth 18
            t_left[40 + i] = leaf(8'(i));
            t_right[40 + i] = (i == 17) ? leaf(8'd18) : inode(41 + i);
        end
        load_tree(40, 18);
        apb_write(REG_CTRL, 32'h1);
        wait_done();
        apb_read(REG_STATUS, word);
        check_eq("status flags", 32'h6, word & 32'h7);
        for (int s = 0; s < 256; s++) begin
            apb_write(REG_CB_SEL, s);
            apb_read(REG_CB_DATA, word);
            assert (word[20:16] <= MAX_DEPTH)
                else stop_on_error($sformatf(
                    "FAILED cb_data[0x%h] length expected <= 0x%h actual 0x%h",
                    8'(s), MAX_DEPTH, word[20:16]));
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/huff_pkg.sv
rtl/cb_entry_if.sv
rtl/huff_apb_regs.sv
rtl/htree_ram.sv
rtl/cb_walker.sv
rtl/codebook_store.sv
rtl/huff_cb_top.sv
tb/tb_huff_cb.sv
